/* files.f */
logic/sv32_pkg.sv
logic/mmu_ifs.sv
logic/sv32_tlb.sv
logic/sv32_ptw.sv
logic/pte_checker.sv
logic/sv32_mmu.sv
tb/tb_sv32_mmu.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_sv32_mmu
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "TEST OK" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb/tb_sv32_mmu.sv */
module tb_sv32_mmu import sv32_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int          TLB_N    = 4;
    localparam int          N_REQ    = 400;
    localparam int          TIMEOUT  = 200;
    localparam logic [21:0] SATP_PPN = 22'h00040;

    localparam logic [7:0] F_V = 8'b1 << PTE_V;
    localparam logic [7:0] F_R = 8'b1 << PTE_R;
    localparam logic [7:0] F_W = 8'b1 << PTE_W;
    localparam logic [7:0] F_X = 8'b1 << PTE_X;
    localparam logic [7:0] F_A = 8'b1 << PTE_A;
    localparam logic [7:0] F_D = 8'b1 << PTE_D;

    logic        clk;
    logic        rst_n;
    logic        req_valid_i;
    logic [31:0] vaddr_i;
    logic        is_store_i;
    logic        mxr_i;
    logic        enable_i;
    logic        flush_i;
    logic        busy_o;
    logic        resp_valid_o;
    logic [31:0] paddr_o;
    logic        page_fault_o;
    logic        mem_req_o;
    logic [31:0] mem_addr_o;
    logic [31:0] mem_rdata_i  = '0;
    logic        mem_rvalid_i = 1'b0;

    sv32_mmu #(
        .TLB_ENTRIES (TLB_N)
    ) uut (
        .clk          (clk),
        .rst_n        (rst_n),
        .req_valid_i  (req_valid_i),
        .vaddr_i      (vaddr_i),
        .is_store_i   (is_store_i),
        .satp_ppn_i   (SATP_PPN),
        .mxr_i        (mxr_i),
        .enable_i     (enable_i),
        .flush_i      (flush_i),
        .busy_o       (busy_o),
        .resp_valid_o (resp_valid_o),
        .paddr_o      (paddr_o),
        .page_fault_o (page_fault_o),
        .mem_req_o    (mem_req_o),
        .mem_addr_o   (mem_addr_o),
        .mem_rdata_i  (mem_rdata_i),
        .mem_rvalid_i (mem_rvalid_i)
    );

    always #20 clk = ~clk;

    logic [31:0] pt_mem [logic [31:0]];
    logic [31:0] seen_addrs [$];
    logic [31:0] exp_addrs [$];
    logic [31:0] rng;
    logic [31:0] mem_rng;
    logic        mem_pending = 1'b0;
    int          mem_wait;
    logic [31:0] mem_addr_q;
    logic [19:0] tlb_vpn [TLB_N];
    logic        tlb_4m [TLB_N];
    logic        tlb_v [TLB_N];
    int          tlb_ptr;
    int          mismatch_cnt;
    int          timeout_cnt;
    logic        hung;
    logic [31:0] prev_va;
    logic        prev_st;
    logic        prev_mx;
    logic        prev_en;
    logic [31:0] last_ok_va;
    logic        last_ok_st;
    logic        last_ok_mx;
    logic        have_last_ok;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] pt_read(input logic [31:0] addr);
        if (pt_mem.exists(addr)) begin
            return pt_mem[addr];
        end
        return {addr[31:2] ^ 30'h2aa55a5a, 2'b10}; // unmapped words have V clear
    endfunction

    function automatic logic tlb_hit(input logic [31:0] va);
        logic h;
        h = 1'b0;
        for (int i = 0; i < TLB_N; i++) begin
            if (tlb_v[i] && (tlb_4m[i] ? (tlb_vpn[i][19:10] == va[31:22])
                                       : (tlb_vpn[i] == va[31:12]))) begin
                h = 1'b1;
            end
        end
        return h;
    endfunction

    task automatic report_error(input string msg);
        mismatch_cnt++;
        $display("[ERROR] %0t: %s", $time, msg);
    endtask

    task automatic report_timeout(input string what);
        timeout_cnt++;
        hung = 1'b1;
        $display("timeout while waiting for %s", what);
    endtask

    // root table at satp with l2 tables behind the pointer entries
    task automatic build_table();
        logic [21:0] ppn;
        logic [7:0]  fl;
        for (int i = 0; i < 16; i++) begin
            rng = xorshift(rng);
            ppn = {2'b00, rng[19:10], 10'h000};
            case (i % 8)
                0, 5: begin
                    ppn = 22'h00100 + 22'(i);
                    fl  = F_V;
                end
                1: fl = F_V | F_R | F_W | F_X | F_A | F_D;
                2: begin
                    ppn[9:0] = rng[9:0] | 10'h001; // misaligned superpage
                    fl       = F_V | F_R | F_W | F_A | F_D;
                end
                3: fl = F_R | F_W | F_A | F_D;
                4: fl = F_V | F_W | F_A | F_D;
                6: fl = F_V | F_X | F_A;
                default: fl = F_V | F_R | F_A;
            endcase
            pt_mem[{SATP_PPN[19:0], 10'(i), 2'b00}] = {ppn, 2'b00, fl};
            if (i % 8 == 0 || i % 8 == 5) begin
                for (int j = 0; j < 8; j++) begin
                    rng = xorshift(rng);
                    case ((i + j) % 8)
                        0: fl = F_V | F_R | F_W | F_A | F_D;
                        1: fl = F_V | F_R | F_A;
                        2: fl = F_V | F_X | F_A;
                        3: fl = F_R;
                        4: fl = F_V; // pointer at the last level
                        5: fl = F_V | F_R | F_W;
                        6: fl = F_V | F_W | F_A | F_D;
                        default: fl = F_V | F_R | F_W | F_X | F_A | F_D;
                    endcase
                    pt_mem[{ppn[19:0], 10'(j), 2'b00}] = {rng[21:0], 2'b00, fl};
                end
            end
        end
    endtask

    task automatic ref_translate(input logic [31:0] va, input logic st, input logic mx,
                                 input logic en, output logic [31:0] pa, output logic flt,
                                 output logic is_4m, output logic fill);
        logic [31:0] a;
        pte_t        p;
        logic        leaf;
        exp_addrs.delete();
        pa    = va;
        flt   = 1'b0;
        leaf  = 1'b0;
        is_4m = 1'b0;
        p     = '0;
        for (int lvl = 1; en && lvl <= 2 && !leaf && !flt; lvl++) begin
            a = (lvl == 1) ? {SATP_PPN[19:0], va[31:22], 2'b00}
                           : {p.ppn1[9:0], p.ppn0, va[21:12], 2'b00};
            exp_addrs.push_back(a);
            p     = pte_t'(pt_read(a));
            is_4m = (lvl == 1);
            if (!p.flags[PTE_V] || (p.flags[PTE_W] && !p.flags[PTE_R])) begin
                flt = 1'b1;
            end else if (p.flags[PTE_R] || p.flags[PTE_X]) begin
                leaf = 1'b1;
            end else if (lvl == 2) begin
                flt = 1'b1;
            end
        end
        if (leaf) begin
            if (is_4m && p.ppn0 != '0) begin
                flt = 1'b1;
            end else if (st) begin
                flt = !(p.flags[PTE_A] && p.flags[PTE_D] && p.flags[PTE_W]);
            end else begin
                flt = !(p.flags[PTE_A] && (p.flags[PTE_R] || (p.flags[PTE_X] && mx)));
            end
            pa = is_4m ? {p.ppn1[9:0], va[21:0]} : {p.ppn1[9:0], p.ppn0, va[11:0]};
        end
        fill = leaf && !flt;
    endtask

    task automatic wait_not_busy();
        int n;
        n = 0;
        while (busy_o && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (busy_o) begin
            report_timeout("busy_o to fall");
        end
    endtask

    task automatic run_request(input logic [31:0] va, input logic st, input logic mx,
                               input logic en);
        logic [31:0] exp_pa;
        logic        exp_flt;
        logic        is_4m;
        logic        fill;
        logic        hit;
        int          cycles;
        hit = en && tlb_hit(va);
        ref_translate(va, st, mx, en, exp_pa, exp_flt, is_4m, fill);
        if (hit) begin
            exp_addrs.delete(); // served from the tlb
            fill = 1'b0;
        end
        seen_addrs.delete();
        @(posedge clk);
        req_valid_i <= 1'b1;
        vaddr_i     <= va;
        is_store_i  <= st;
        mxr_i       <= mx;
        enable_i    <= en;
        @(posedge clk);
        req_valid_i <= 1'b0;
        cycles = 1;
        @(negedge clk);
        while (!resp_valid_o && !page_fault_o && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!resp_valid_o && !page_fault_o) begin
            report_timeout($sformatf("a response to vaddr %h", va));
        end else begin
            if ((hit || !en) && cycles != 3) begin
                report_error($sformatf("vaddr %h answered after %0d cycles, expected 3",
                                       va, cycles));
            end
            if (resp_valid_o && page_fault_o) begin
                report_error($sformatf("vaddr %h got response and fault together", va));
            end
            if (page_fault_o != exp_flt) begin
                report_error($sformatf("vaddr %h st %0b mxr %0b fault %0b, expected %0b",
                                       va, st, mx, page_fault_o, exp_flt));
            end else if (!exp_flt && paddr_o != exp_pa) begin
                report_error($sformatf("vaddr %h paddr %h, expected %h", va, paddr_o, exp_pa));
            end
            if (seen_addrs.size() != exp_addrs.size()) begin
                report_error($sformatf("vaddr %h made %0d memory reads, expected %0d",
                                       va, seen_addrs.size(), exp_addrs.size()));
            end else begin
                foreach (exp_addrs[i]) begin
                    if (seen_addrs[i] != exp_addrs[i]) begin
                        report_error($sformatf("pte read %0d at %h, expected %h",
                                               i, seen_addrs[i], exp_addrs[i]));
                    end
                end
            end
            if (fill) begin
                tlb_vpn[tlb_ptr] = va[31:12];
                tlb_4m[tlb_ptr]  = is_4m;
                tlb_v[tlb_ptr]   = 1'b1;
                tlb_ptr          = (tlb_ptr + 1) % TLB_N;
            end
            if (en && !exp_flt) begin
                last_ok_va   = va;
                last_ok_st   = st;
                last_ok_mx   = mx;
                have_last_ok = 1'b1;
            end
            wait_not_busy();
        end
        prev_va = va;
        prev_st = st;
        prev_mx = mx;
        prev_en = en;
    endtask

    // flush as soon as the walk reaches memory
    task automatic run_flush(input logic [31:0] va);
        int   n;
        logic got_reply;
        @(posedge clk);
        req_valid_i <= 1'b1;
        vaddr_i     <= va;
        is_store_i  <= 1'b0;
        enable_i    <= 1'b1;
        @(posedge clk);
        req_valid_i <= 1'b0;
        n = 0;
        @(negedge clk);
        while (!mem_req_o && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!mem_req_o) begin
            report_timeout("mem_req_o before the flush");
        end else begin
            @(posedge clk);
            flush_i <= 1'b1;
            @(posedge clk);
            flush_i <= 1'b0;
            for (int i = 0; i < TLB_N; i++) begin
                tlb_v[i] = 1'b0;
            end
            got_reply = 1'b0;
            n = 0;
            @(negedge clk);
            while (busy_o && n < TIMEOUT) begin
                got_reply = got_reply || mem_rvalid_i;
                if (resp_valid_o || page_fault_o) begin
                    report_error($sformatf("flushed vaddr %h still gave a response", va));
                end
                @(negedge clk);
                n++;
            end
            if (busy_o) begin
                report_timeout("busy_o to fall after a flush");
            end else if (!got_reply) begin
                report_error("busy_o fell before the pending memory reply");
            end
        end
    endtask

    // page table memory replying 1 to 4 cycles after a request
    always @(posedge clk) begin
        mem_rvalid_i <= 1'b0;
        if (!rst_n) begin
            mem_pending <= 1'b0;
        end else if (mem_pending) begin
            if (mem_wait == 0) begin
                mem_rvalid_i <= 1'b1;
                mem_rdata_i  <= pt_read(mem_addr_q);
                mem_pending  <= 1'b0;
            end else begin
                mem_wait <= mem_wait - 1;
            end
        end else if (mem_req_o && !mem_rvalid_i) begin
            mem_rng = xorshift(mem_rng);
            mem_pending <= 1'b1;
            mem_wait    <= int'(mem_rng[1:0]);
            mem_addr_q  <= mem_addr_o;
            seen_addrs.push_back(mem_addr_o);
        end
    end

    initial begin
        logic [31:0] r1;
        logic [31:0] r2;
        logic [31:0] va;
        clk          = 1'b0;
        rst_n        = 1'b0;
        req_valid_i <= 1'b0;
        vaddr_i     <= '0;
        is_store_i  <= 1'b0;
        mxr_i       <= 1'b0;
        enable_i    <= 1'b0;
        flush_i     <= 1'b0;
        rng          = 32'd36413;
        mem_rng      = xorshift(xorshift(32'd36413 ^ 32'h5bd1e995));
        mismatch_cnt = 0;
        timeout_cnt  = 0;
        hung         = 1'b0;
        tlb_ptr      = 0;
        have_last_ok = 1'b0;
        prev_en      = 1'b0;
        for (int i = 0; i < TLB_N; i++) begin
            tlb_v[i] = 1'b0;
        end
        build_table();
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        if (busy_o || resp_valid_o || page_fault_o || mem_req_o) begin
            report_error("outputs not idle after reset");
        end
        for (int k = 0; k < N_REQ && !hung; k++) begin
            rng = xorshift(rng);
            r1  = rng;
            rng = xorshift(rng);
            r2  = rng;
            va  = {6'b0, r1[3:0], r1[4] ? r1[14:5] : {7'b0, r1[7:5]}, r2[11:0]};
            if (r2[22:19] == 4'h0 && have_last_ok) begin
                run_flush({6'b000001, r1[3:0], r1[14:5], r2[11:0]});
                if (!hung) begin
                    run_request(last_ok_va, last_ok_st, last_ok_mx, 1'b1); // walks again
                end
            end else if (r2[18:17] == 2'b00 && k > 0) begin
                run_request(prev_va, prev_st, prev_mx, prev_en);
            end else begin
                run_request(va, r2[12], r2[13], r2[16:14] != 3'b000);
            end
        end
        $display("%0d value errors, %0d timeouts", mismatch_cnt, timeout_cnt);
        if (mismatch_cnt == 0 && timeout_cnt == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* logic/sv32_mmu.sv */
module sv32_mmu #(
    parameter int TLB_ENTRIES = 4 // power of two from 2 to 16
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        req_valid_i,
    input  logic [31:0] vaddr_i,
    input  logic        is_store_i,
    input  logic [21:0] satp_ppn_i,
    input  logic        mxr_i,
    input  logic        enable_i,
    input  logic        flush_i,
    output logic        busy_o,
    output logic        resp_valid_o,
    output logic [31:0] paddr_o,
    output logic        page_fault_o,
    output logic        mem_req_o,
    output logic [31:0] mem_addr_o,
    input  logic [31:0] mem_rdata_i,
    input  logic        mem_rvalid_i
);

    lookup_if lk_if ();
    leaf_if   lf_if ();
    retire_if rt_if ();

    sv32_tlb #(
        .TLB_ENTRIES (TLB_ENTRIES)
    ) u_tlb (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_valid_i (req_valid_i),
        .vaddr_i     (vaddr_i),
        .is_store_i  (is_store_i),
        .flush_i     (flush_i),
        .busy_o      (busy_o),
        .lk          (lk_if.tlb),
        .rt          (rt_if.tlb)
    );

    sv32_ptw u_ptw (
        .clk          (clk),
        .rst_n        (rst_n),
        .enable_i     (enable_i),
        .flush_i      (flush_i),
        .satp_ppn_i   (satp_ppn_i),
        .mem_req_o    (mem_req_o),
        .mem_addr_o   (mem_addr_o),
        .mem_rdata_i  (mem_rdata_i),
        .mem_rvalid_i (mem_rvalid_i),
        .lk           (lk_if.ptw),
        .lf           (lf_if.ptw)
    );

    pte_checker u_chk (
        .clk          (clk),
        .rst_n        (rst_n),
        .mxr_i        (mxr_i),
        .resp_valid_o (resp_valid_o),
        .paddr_o      (paddr_o),
        .page_fault_o (page_fault_o),
        .lf           (lf_if.chk),
        .rt           (rt_if.chk)
    );

endmodule

/* logic/pte_checker.sv */
module pte_checker import sv32_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        mxr_i,
    output logic        resp_valid_o,
    output logic [31:0] paddr_o,
    output logic        page_fault_o,
    leaf_if.chk         lf,
    retire_if.chk       rt
);

    logic [7:0]  fl;
    logic        misaligned;
    logic        perm_ok;
    logic        page_ok;
    logic        is_page;
    logic [31:0] leaf_paddr;

    assign fl         = lf.pte.flags;
    assign is_page    = (lf.kind == LEAF_PAGE);
    assign misaligned = (lf.size == PAGE_4M) && (lf.pte.ppn0 != '0); // superpage low ppn must be 0

    always_comb begin
        if (lf.is_store) begin
            perm_ok = fl[PTE_A] && fl[PTE_D] && fl[PTE_W];
        end else begin
            perm_ok = fl[PTE_A] && (fl[PTE_R] || (fl[PTE_X] && mxr_i));
        end
    end

    assign page_ok = perm_ok && !misaligned;

    always_comb begin
        if (lf.kind == LEAF_BARE) begin
            leaf_paddr = lf.vaddr;
        end else if (lf.size == PAGE_4M) begin
            leaf_paddr = {lf.pte.ppn1[9:0], lf.vaddr[21:0]};
        end else begin
            leaf_paddr = {lf.pte.ppn1[9:0], lf.pte.ppn0, lf.vaddr[11:0]};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            resp_valid_o <= 1'b0;
            page_fault_o <= 1'b0;
            rt.done      <= 1'b0;
            rt.fill      <= 1'b0;
        end else begin
            resp_valid_o <= lf.valid && ((is_page && page_ok) || lf.kind == LEAF_BARE);
            page_fault_o <= lf.valid && ((is_page && !page_ok) || lf.kind == LEAF_FAULT);
            rt.done      <= lf.valid; // aborts retire silently
            rt.fill      <= lf.valid && is_page && page_ok && lf.from_walk;
        end
    end

    always_ff @(posedge clk) begin
        if (lf.valid) begin
            paddr_o <= leaf_paddr;
            rt.vpn  <= lf.vaddr[31:12];
            rt.pte  <= lf.pte;
            rt.size <= lf.size;
        end
    end

endmodule

/* logic/sv32_ptw.sv */
module sv32_ptw import sv32_pkg::*; (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             enable_i,
    input  logic             flush_i,
    input  logic [PPN_W-1:0] satp_ppn_i,
    output logic             mem_req_o,
    output logic [31:0]      mem_addr_o,
    input  logic [31:0]      mem_rdata_i,
    input  logic             mem_rvalid_i,
    lookup_if.ptw            lk,
    leaf_if.ptw              lf
);

    walk_state_e state;
    page_size_e  level_q; // PAGE_4M while on level 1
    logic [31:0] vaddr_q;
    logic        is_store_q;
    pte_t        pte_q;
    leaf_kind_e  kind_q;
    logic        from_walk_q;
    logic [31:0] mem_addr_q;

    logic [19:0] table_ppn;
    logic [9:0]  vpn_idx;
    logic        pte_bad;
    logic        pte_leaf;

    // level 2 table comes from the pointer pte still in pte_q
    assign table_ppn = (level_q == PAGE_4M) ? satp_ppn_i[19:0] : {pte_q.ppn1[9:0], pte_q.ppn0};
    assign vpn_idx   = (level_q == PAGE_4M) ? vaddr_q[31:22] : vaddr_q[21:12];
    assign pte_bad   = !pte_q.flags[PTE_V] || (pte_q.flags[PTE_W] && !pte_q.flags[PTE_R]);
    assign pte_leaf  = pte_q.flags[PTE_R] || pte_q.flags[PTE_X];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= WALK_IDLE;
            level_q     <= PAGE_4M;
            vaddr_q     <= '0;
            is_store_q  <= 1'b0;
            pte_q       <= '0;
            kind_q      <= LEAF_BARE;
            from_walk_q <= 1'b0;
            mem_addr_q  <= '0;
        end else begin
            case (state)
                WALK_IDLE: if (lk.valid) begin
                    vaddr_q     <= lk.vaddr;
                    is_store_q  <= lk.is_store;
                    pte_q       <= lk.pte;
                    level_q     <= lk.hit ? lk.size : PAGE_4M;
                    from_walk_q <= 1'b0;
                    if (!enable_i) begin
                        kind_q <= LEAF_BARE;
                        state  <= WALK_EMIT;
                    end else if (lk.hit) begin
                        kind_q <= LEAF_PAGE;
                        state  <= WALK_EMIT;
                    end else begin
                        state <= WALK_LOOKUP;
                    end
                end
                WALK_LOOKUP: begin
                    mem_addr_q <= {table_ppn, vpn_idx, 2'b00};
                    kind_q     <= LEAF_ABORT;
                    state      <= flush_i ? WALK_EMIT : WALK_MEM;
                end
                WALK_MEM: begin
                    if (mem_rvalid_i) begin
                        pte_q <= pte_t'(mem_rdata_i);
                    end
                    if (flush_i) begin
                        state <= mem_rvalid_i ? WALK_EMIT : WALK_DRAIN; // kind_q still ABORT
                    end else if (mem_rvalid_i) begin
                        state <= WALK_PTE;
                    end
                end
                WALK_PTE: begin
                    state <= WALK_EMIT;
                    if (flush_i) begin
                        kind_q <= LEAF_ABORT;
                    end else if (pte_bad) begin
                        kind_q <= LEAF_FAULT;
                    end else if (pte_leaf) begin
                        kind_q      <= LEAF_PAGE;
                        from_walk_q <= 1'b1;
                    end else if (level_q == PAGE_4M) begin
                        level_q <= PAGE_4K; // descend through the pointer
                        state   <= WALK_LOOKUP;
                    end else begin
                        kind_q <= LEAF_FAULT;
                    end
                end
                WALK_DRAIN: if (mem_rvalid_i) begin
                    state <= WALK_EMIT;
                end
                default: state <= WALK_IDLE; // WALK_EMIT lasts one cycle
            endcase
        end
    end

    assign lf.valid     = (state == WALK_EMIT);
    assign lf.kind      = kind_q;
    assign lf.vaddr     = vaddr_q;
    assign lf.is_store  = is_store_q;
    assign lf.pte       = pte_q;
    assign lf.size      = level_q;
    assign lf.from_walk = from_walk_q;

    assign mem_req_o  = (state == WALK_MEM);
    assign mem_addr_o = mem_addr_q;

endmodule

/* logic/sv32_tlb.sv */
module sv32_tlb import sv32_pkg::*; #(
    parameter int TLB_ENTRIES = 4
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        req_valid_i,
    input  logic [31:0] vaddr_i,
    input  logic        is_store_i,
    input  logic        flush_i,
    output logic        busy_o,
    lookup_if.tlb       lk,
    retire_if.tlb       rt
);

    localparam int IDX_W = $clog2(TLB_ENTRIES);

    logic [TLB_ENTRIES-1:0] ent_valid;
    logic [VPN_W-1:0]       ent_vpn  [TLB_ENTRIES];
    pte_t                   ent_pte  [TLB_ENTRIES];
    page_size_e             ent_size [TLB_ENTRIES];
    logic [IDX_W-1:0]       fill_ptr; // round robin victim

    logic                   busy_q;
    logic                   accept;
    logic [VPN_W-1:0]       req_vpn;
    logic [TLB_ENTRIES-1:0] match;
    logic                   hit_c;
    pte_t                   hit_pte_c;
    page_size_e             hit_size_c;

    assign req_vpn = vaddr_i[31:12];
    assign accept  = req_valid_i && !busy_q;
    assign busy_o  = busy_q;

    always_comb begin
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            if (ent_size[i] == PAGE_4M) begin
                match[i] = ent_valid[i] && (ent_vpn[i][19:10] == req_vpn[19:10]);
            end else begin
                match[i] = ent_valid[i] && (ent_vpn[i] == req_vpn);
            end
        end
    end

    always_comb begin
        hit_pte_c  = '0;
        hit_size_c = PAGE_4K;
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            if (match[i]) begin
                hit_pte_c  = ent_pte[i];
                hit_size_c = ent_size[i];
            end
        end
    end

    assign hit_c = (|match) && !flush_i; // entries die this cycle on flush

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q   <= 1'b0;
            lk.valid <= 1'b0;
        end else begin
            lk.valid <= accept;
            if (accept) begin
                busy_q <= 1'b1;
            end else if (rt.done) begin
                busy_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            lk.vaddr    <= vaddr_i;
            lk.is_store <= is_store_i;
            lk.hit      <= hit_c;
            lk.pte      <= hit_pte_c;
            lk.size     <= hit_size_c;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ent_valid <= '0;
            fill_ptr  <= '0;
        end else if (flush_i) begin
            ent_valid <= '0;
        end else if (rt.fill) begin
            ent_valid[fill_ptr] <= 1'b1;
            fill_ptr            <= fill_ptr + IDX_W'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (rt.fill && !flush_i) begin
            ent_vpn[fill_ptr]  <= rt.vpn;
            ent_pte[fill_ptr]  <= rt.pte;
            ent_size[fill_ptr] <= rt.size;
        end
    end

endmodule

/* logic/mmu_ifs.sv */
// registered request plus tlb search result
interface lookup_if import sv32_pkg::*; ();
    logic       valid;
    logic [31:0] vaddr;
    logic       is_store;
    logic       hit;
    pte_t       pte;
    page_size_e size;

    modport tlb (output valid, vaddr, is_store, hit, pte, size);
    modport ptw (input  valid, vaddr, is_store, hit, pte, size);
endinterface

// one walk outcome pulse per request
interface leaf_if import sv32_pkg::*; ();
    logic        valid;
    leaf_kind_e  kind;
    logic [31:0] vaddr;
    logic        is_store;
    pte_t        pte;
    page_size_e  size;
    logic        from_walk;

    modport ptw (output valid, kind, vaddr, is_store, pte, size, from_walk);
    modport chk (input  valid, kind, vaddr, is_store, pte, size, from_walk);
endinterface

interface retire_if import sv32_pkg::*; ();
    logic             done;
    logic             fill;
    logic [VPN_W-1:0] vpn;
    pte_t             pte;
    page_size_e       size;

    modport chk (output done, fill, vpn, pte, size);
    modport tlb (input  done, fill, vpn, pte, size);
endinterface

/* logic/sv32_pkg.sv */
package sv32_pkg;

    // flag bit positions in a pte
    localparam int PTE_V = 0;
    localparam int PTE_R = 1;
    localparam int PTE_W = 2;
    localparam int PTE_X = 3;
    localparam int PTE_U = 4;
    localparam int PTE_G = 5;
    localparam int PTE_A = 6;
    localparam int PTE_D = 7;

    localparam int VPN_W = 20;
    localparam int PPN_W = 22; // only the low 20 bits reach the bus

    typedef enum logic {
        PAGE_4K,
        PAGE_4M
    } page_size_e;

    typedef enum logic [1:0] {
        LEAF_PAGE,  // leaf pte to check
        LEAF_BARE,  // translation off
        LEAF_FAULT, // walk failed
        LEAF_ABORT  // walk flushed
    } leaf_kind_e;

    typedef struct packed {
        logic [11:0] ppn1;
        logic [9:0]  ppn0;
        logic [1:0]  rsw;
        logic [7:0]  flags;
    } pte_t;

    typedef enum logic [2:0] {
        WALK_IDLE,
        WALK_LOOKUP,
        WALK_MEM,
        WALK_PTE,
        WALK_DRAIN,
        WALK_EMIT
    } walk_state_e;

endpackage
